// File: tb.f
common/alu_iq_pkg.sv
rtl/dispatch_ctrl.sv
issue_queue/iq_entry.sv
issue_queue/issue_queue.sv
rtl/alu_exec.sv
rtl/alu_issue_top.sv
testbench/tb_alu_issue.sv

// File: Bender.yml
package:
  name: alu_issue

sources:
  - files:
      - common/alu_iq_pkg.sv
      - rtl/dispatch_ctrl.sv
      - issue_queue/iq_entry.sv
      - issue_queue/issue_queue.sv
      - rtl/alu_exec.sv
      - rtl/alu_issue_top.sv
  - target: test
    files:
      - testbench/tb_alu_issue.sv

// File: testbench/tb_alu_issue.sv
module tb_alu_issue import alu_iq_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_INSTR   = 300;
    localparam int N_ALU_TAG = 8;
    localparam int N_TAG     = 2 ** TAG_W;
    localparam int BP_FIRST  = 150;
    localparam int BP_LAST   = 200;
    localparam int MAX_CYC   = 40 * N_INSTR + 100;

    logic                   clk;
    logic                   arst_n_i;
    logic                   dsp_req_i;
    alu_op_e                dsp_op_i;
    logic [TAG_W-1:0]       dsp_dst_tag_i;
    logic [1:0]             dsp_src_rdy_i;
    logic [1:0][TAG_W-1:0]  dsp_src_tag_i;
    logic [1:0][DATA_W-1:0] dsp_src_data_i;
    logic                   dsp_ack_o;
    logic                   cdb_valid_i;
    logic [TAG_W-1:0]       cdb_tag_i;
    logic [DATA_W-1:0]      cdb_data_i;
    logic                   res_req_o;
    logic                   res_ack_i;
    logic [TAG_W-1:0]       res_tag_o;
    logic [DATA_W-1:0]      res_data_o;

    // reference model, ALU tags 0..7 and external tags 8..15
    logic                   in_flight [N_ALU_TAG];
    alu_op_e                m_op      [N_ALU_TAG];
    logic [1:0]             m_rdy     [N_ALU_TAG];
    logic [1:0][TAG_W-1:0]  m_tag     [N_ALU_TAG];
    logic [1:0][DATA_W-1:0] m_val     [N_ALU_TAG];
    string                  m_test    [N_ALU_TAG];
    logic                   val_known [N_TAG];
    logic [DATA_W-1:0]      tag_val   [N_TAG];
    logic                   ext_pend  [N_TAG];
    int                     ext_wait  [N_TAG];

    logic [31:0]            lfsr_q;
    int                     cycles;
    int                     num_disp;
    int                     num_acc;
    int                     num_res;
    int                     mismatches;
    int                     failures;
    int                     d_state;
    int                     a_state;
    int                     ack_wait;
    logic                   bcast_now;
    logic                   prev_req;
    logic                   prev_ack;
    logic                   prev_dsp_req;
    logic                   prev_dsp_ack;
    logic [TAG_W-1:0]       prev_tag;
    logic [DATA_W-1:0]      prev_data;

    alu_issue_top alu_issue_top_inst (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .dsp_req_i      (dsp_req_i),
        .dsp_op_i       (dsp_op_i),
        .dsp_dst_tag_i  (dsp_dst_tag_i),
        .dsp_src_rdy_i  (dsp_src_rdy_i),
        .dsp_src_tag_i  (dsp_src_tag_i),
        .dsp_src_data_i (dsp_src_data_i),
        .dsp_ack_o      (dsp_ack_o),
        .cdb_valid_i    (cdb_valid_i),
        .cdb_tag_i      (cdb_tag_i),
        .cdb_data_i     (cdb_data_i),
        .res_req_o      (res_req_o),
        .res_ack_i      (res_ack_i),
        .res_tag_o      (res_tag_o),
        .res_data_o     (res_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------
    // random source and model
    // ------------------------------
    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic logic [DATA_W-1:0] alu_ref(input alu_op_e op,
                                                  input logic [DATA_W-1:0] a,
                                                  input logic [DATA_W-1:0] b);
        logic [DATA_W-1:0] r;
        case (op)
            ADD:     r = a + b;
            SUB:     r = a + ~b + 1'b1;
            AND:     r = a & b;
            OR:      r = a | b;
            XOR:     r = a ^ b;
            SLL:     r = a << b[3:0];
            SRL:     r = a >> b[3:0];
            default: begin
                // signed less-than from the sign bits first
                if (a[DATA_W-1] != b[DATA_W-1]) begin
                    r = DATA_W'(a[DATA_W-1]);
                end else begin
                    r = DATA_W'(a < b);
                end
            end
        endcase
        return r;
    endfunction

    // in-flight instructions still waiting on an unsent CDB tag
    function automatic int blocked_count();
        int n;
        n = 0;
        for (int i = 0; i < N_ALU_TAG; i++) begin
            if (in_flight[i] && !val_known[i]) n++;
        end
        return n;
    endfunction

    function automatic string phase_name(input int idx);
        if (idx < 8) return "ready_ops";
        if (idx >= BP_FIRST && idx < BP_LAST) return "back_pressure";
        return "random";
    endfunction

    // a known value wakes every waiter, results ripple down chains
    task automatic resolve_tag(input int t, input logic [DATA_W-1:0] v);
        val_known[t] = 1'b1;
        tag_val[t]   = v;
        for (int i = 0; i < N_ALU_TAG; i++) begin
            if (in_flight[i] && !val_known[i]) begin
                for (int s = 0; s < 2; s++) begin
                    if (!m_rdy[i][s] && m_tag[i][s] == t) begin
                        m_rdy[i][s] = 1'b1;
                        m_val[i][s] = v;
                    end
                end
                if (&m_rdy[i]) resolve_tag(i, alu_ref(m_op[i], m_val[i][0], m_val[i][1]));
            end
        end
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR at cycle %0d: %s", cycles, msg);
        failures++;
    endtask

    // ------------------------------
    // port monitors
    // ------------------------------
    task automatic check_ports();
        int t;
        if (prev_req && !prev_ack && !res_req_o)
            report_failure("result request dropped before it was acknowledged");
        if (prev_req && res_req_o && (res_tag_o !== prev_tag || res_data_o !== prev_data))
            report_failure("result payload changed while the request was high");
        if (res_req_o && !prev_req) begin
            num_res++;
            if ($isunknown(res_tag_o) || res_tag_o >= N_ALU_TAG || !in_flight[res_tag_o]) begin
                report_failure($sformatf("unexpected or duplicate result tag %h", res_tag_o));
            end else begin
                t = res_tag_o;
                if (!val_known[t]) begin
                    report_failure($sformatf("result for tag %0d came before its operands", t));
                end else if (res_data_o !== tag_val[t]) begin
                    $display("MISMATCH test=%s tag=%0d expected=%h actual=%h",
                             m_test[t], t, tag_val[t], res_data_o);
                    mismatches++;
                end
                in_flight[t] = 1'b0;
            end
        end
        if (prev_dsp_ack && !dsp_ack_o && prev_dsp_req)
            report_failure("dispatch ack fell while the request was still high");
        if (num_acc - num_res > IQ_SIZE + 1)
            report_failure("more instructions accepted than the queue can hold");
        prev_req     = res_req_o;
        prev_ack     = res_ack_i;
        prev_tag     = res_tag_o;
        prev_data    = res_data_o;
        prev_dsp_req = dsp_req_i;
        prev_dsp_ack = dsp_ack_o;
    endtask

    // ------------------------------
    // drivers
    // ------------------------------
    task automatic drive_result_ack();
        case (a_state)
            0: begin
                if (res_req_o && !prev_ack) begin
                    // long holds fill the queue and stall dispatch
                    if (num_res >= BP_FIRST && num_res < BP_LAST) begin
                        ack_wait = 30 + rand_bits(4);
                    end else begin
                        ack_wait = rand_bits(2);
                    end
                    a_state = 1;
                end
            end
            1: begin
                if (ack_wait == 0) begin
                    res_ack_i <= 1'b1;
                    a_state = 2;
                end else begin
                    ack_wait--;
                end
            end
            default: begin
                if (!res_req_o) begin
                    res_ack_i <= 1'b0;
                    a_state = 0;
                end
            end
        endcase
    endtask

    task automatic advance_dispatch();
        if (d_state == 1 && dsp_ack_o) begin
            dsp_req_i <= 1'b0;
            num_acc++;
            d_state = 2;
        end else if (d_state == 2 && !dsp_ack_o) begin
            d_state = 0;
        end
    endtask

    // broadcasts only while no dispatch is in progress
    task automatic drive_cdb();
        logic [DATA_W-1:0] v;
        bcast_now = 1'b0;
        cdb_valid_i <= 1'b0;
        for (int t = N_ALU_TAG; t < N_TAG; t++) begin
            if (ext_pend[t] && ext_wait[t] > 0) ext_wait[t]--;
        end
        if (d_state != 0) return;
        for (int t = N_ALU_TAG; t < N_TAG; t++) begin
            if (!bcast_now && ext_pend[t] && ext_wait[t] == 0) begin
                v = rand_bits(DATA_W);
                cdb_valid_i <= 1'b1;
                cdb_tag_i   <= TAG_W'(t);
                cdb_data_i  <= v;
                ext_pend[t] = 1'b0;
                resolve_tag(t, v);
                bcast_now = 1'b1;
            end
        end
    endtask

    task automatic start_dispatch();
        int dst;
        int j;
        int start;
        int pick;
        alu_op_e op;
        logic [1:0] rdy;
        logic [1:0][TAG_W-1:0] stag;
        logic [1:0][DATA_W-1:0] sdata;
        if (d_state != 0 || bcast_now || num_disp >= N_INSTR) return;
        if (blocked_count() >= IQ_SIZE) return;
        dst = -1;
        start = rand_bits(3);
        for (int k = 0; k < N_ALU_TAG; k++) begin
            j = (start + k) % N_ALU_TAG;
            if (dst < 0 && !in_flight[j]) dst = j;
        end
        if (dst < 0) return;
        op = (num_disp < 8) ? alu_op_e'(num_disp) : alu_op_e'(rand_bits(3));
        for (int s = 0; s < 2; s++) begin
            pick     = (num_disp < 8) ? 0 : rand_bits(2);
            sdata[s] = rand_bits(DATA_W);
            stag[s]  = '0;
            rdy[s]   = 1'b1;
            if (pick == 2) begin
                stag[s] = TAG_W'(N_ALU_TAG + rand_bits(3));
                rdy[s]  = 1'b0;
                if (!ext_pend[stag[s]]) begin
                    ext_pend[stag[s]] = 1'b1;
                    ext_wait[stag[s]] = rand_bits(4);
                end
            end else if (pick == 3) begin
                start = rand_bits(3);
                for (int k = 0; k < N_ALU_TAG; k++) begin
                    j = (start + k) % N_ALU_TAG;
                    if (rdy[s] && in_flight[j] && !val_known[j]) begin
                        stag[s] = TAG_W'(j);
                        rdy[s]  = 1'b0;
                    end
                end
            end
        end
        in_flight[dst] = 1'b1;
        val_known[dst] = 1'b0;
        m_op[dst]      = op;
        m_rdy[dst]     = rdy;
        m_tag[dst]     = stag;
        m_val[dst]     = sdata;
        m_test[dst]    = phase_name(num_disp);
        if (&rdy) resolve_tag(dst, alu_ref(op, sdata[0], sdata[1]));
        dsp_req_i      <= 1'b1;
        dsp_op_i       <= op;
        dsp_dst_tag_i  <= TAG_W'(dst);
        dsp_src_rdy_i  <= rdy;
        dsp_src_tag_i  <= stag;
        dsp_src_data_i <= sdata;
        num_disp++;
        d_state = 1;
    endtask

    // every ALU tag has had its result back
    function automatic logic all_answered();
        for (int i = 0; i < N_ALU_TAG; i++) begin
            if (in_flight[i]) return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic logic run_done();
        return num_disp == N_INSTR && all_answered() && d_state == 0 && a_state == 0;
    endfunction

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        lfsr_q         = 32'd94451;
        arst_n_i       = 1'b0;
        dsp_req_i      = 1'b0;
        dsp_op_i       = ADD;
        dsp_dst_tag_i  = '0;
        dsp_src_rdy_i  = '0;
        dsp_src_tag_i  = '0;
        dsp_src_data_i = '0;
        cdb_valid_i    = 1'b0;
        cdb_tag_i      = '0;
        cdb_data_i     = '0;
        res_ack_i      = 1'b0;
        cycles = 0;
        num_disp = 0;
        num_acc = 0;
        num_res = 0;
        mismatches = 0;
        failures = 0;
        d_state = 0;
        a_state = 0;
        ack_wait = 0;
        bcast_now = 1'b0;
        prev_req = 1'b0;
        prev_ack = 1'b0;
        prev_dsp_req = 1'b0;
        prev_dsp_ack = 1'b0;
        prev_tag = '0;
        prev_data = '0;
        for (int i = 0; i < N_TAG; i++) begin
            val_known[i] = 1'b0;
            tag_val[i]   = '0;
            ext_pend[i]  = 1'b0;
            ext_wait[i]  = 0;
        end
        for (int i = 0; i < N_ALU_TAG; i++) in_flight[i] = 1'b0;

        repeat (4) @(posedge clk);
        arst_n_i <= 1'b1;
        @(posedge clk);
        if (dsp_ack_o !== 1'b0 || res_req_o !== 1'b0)
            report_failure("dispatch ack or result request not low after reset");

        while (!run_done() && cycles < MAX_CYC) begin
            @(posedge clk);
            cycles++;
            check_ports();
            drive_result_ack();
            advance_dispatch();
            drive_cdb();
            start_dispatch();
        end

        if (!run_done()) begin
            report_failure($sformatf("timeout after %0d cycles with %0d of %0d results",
                                     cycles, num_res, N_INSTR));
        end else begin
            // nothing more may come out once every tag is answered
            repeat (10) begin
                @(posedge clk);
                cycles++;
                check_ports();
                drive_result_ack();
            end
            if (num_res != num_disp)
                report_failure("result count differs from dispatch count");
        end

        $display("dispatched %0d, results %0d, mismatches %0d, other errors %0d",
                 num_disp, num_res, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: rtl/alu_issue_top.sv
module alu_issue_top import alu_iq_pkg::*; (
    input  logic                          clk,
    input  logic                          arst_n_i,
    // dispatch port
    input  logic                          dsp_req_i,
    input  alu_op_e                       dsp_op_i,
    input  logic [TAG_W-1:0]              dsp_dst_tag_i,
    input  logic [1:0]                    dsp_src_rdy_i,
    input  logic [1:0][TAG_W-1:0]         dsp_src_tag_i,
    input  logic [1:0][DATA_W-1:0]        dsp_src_data_i,
    output logic                          dsp_ack_o,
    // external CDB
    input  logic                          cdb_valid_i,
    input  logic [TAG_W-1:0]              cdb_tag_i,
    input  logic [DATA_W-1:0]             cdb_data_i,
    // result port
    output logic                          res_req_o,
    input  logic                          res_ack_i,
    output logic [TAG_W-1:0]              res_tag_o,
    output logic [DATA_W-1:0]             res_data_o
);

    // allocation
    logic                     alloc_valid;
    logic                     alloc_ready;
    alu_op_e                  alloc_op;
    logic [TAG_W-1:0]         alloc_dst_tag;
    logic [1:0]               alloc_src_rdy;
    logic [1:0][TAG_W-1:0]    alloc_src_tag;
    logic [1:0][DATA_W-1:0]   alloc_src_data;
    // issue
    logic                     iss_valid;
    logic                     iss_ready;
    alu_op_e                  iss_op;
    logic [TAG_W-1:0]         iss_dst_tag;
    logic [1:0][DATA_W-1:0]   iss_src_data;
    // ALU wakeup
    logic                     wk_valid;
    logic [TAG_W-1:0]         wk_tag;
    logic [DATA_W-1:0]        wk_data;

    dispatch_ctrl dispatch_ctrl_inst (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .dsp_req_i        (dsp_req_i),
        .dsp_op_i         (dsp_op_i),
        .dsp_dst_tag_i    (dsp_dst_tag_i),
        .dsp_src_rdy_i    (dsp_src_rdy_i),
        .dsp_src_tag_i    (dsp_src_tag_i),
        .dsp_src_data_i   (dsp_src_data_i),
        .dsp_ack_o        (dsp_ack_o),
        .alloc_valid_o    (alloc_valid),
        .alloc_ready_i    (alloc_ready),
        .alloc_op_o       (alloc_op),
        .alloc_dst_tag_o  (alloc_dst_tag),
        .alloc_src_rdy_o  (alloc_src_rdy),
        .alloc_src_tag_o  (alloc_src_tag),
        .alloc_src_data_o (alloc_src_data)
    );

    issue_queue issue_queue_inst (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .alloc_valid_i    (alloc_valid),
        .alloc_ready_o    (alloc_ready),
        .alloc_op_i       (alloc_op),
        .alloc_dst_tag_i  (alloc_dst_tag),
        .alloc_src_rdy_i  (alloc_src_rdy),
        .alloc_src_tag_i  (alloc_src_tag),
        .alloc_src_data_i (alloc_src_data),
        .cdb_valid_i      (cdb_valid_i),
        .cdb_tag_i        (cdb_tag_i),
        .cdb_data_i       (cdb_data_i),
        .wk_valid_i       (wk_valid),
        .wk_tag_i         (wk_tag),
        .wk_data_i        (wk_data),
        .iss_valid_o      (iss_valid),
        .iss_ready_i      (iss_ready),
        .iss_op_o         (iss_op),
        .iss_dst_tag_o    (iss_dst_tag),
        .iss_src_data_o   (iss_src_data)
    );

    alu_exec alu_exec_inst (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .iss_valid_i      (iss_valid),
        .iss_ready_o      (iss_ready),
        .iss_op_i         (iss_op),
        .iss_dst_tag_i    (iss_dst_tag),
        .iss_src_data_i   (iss_src_data),
        .wk_valid_o       (wk_valid),
        .wk_tag_o         (wk_tag),
        .wk_data_o        (wk_data),
        .res_req_o        (res_req_o),
        .res_ack_i        (res_ack_i),
        .res_tag_o        (res_tag_o),
        .res_data_o       (res_data_o)
    );

endmodule

// File: rtl/alu_exec.sv
module alu_exec import alu_iq_pkg::*; (
    input  logic                          clk,
    input  logic                          arst_n_i,
    // issue port
    input  logic                          iss_valid_i,
    output logic                          iss_ready_o,
    input  alu_op_e                       iss_op_i,
    input  logic [TAG_W-1:0]              iss_dst_tag_i,
    input  logic [1:0][DATA_W-1:0]        iss_src_data_i,
    // wakeup broadcast
    output logic                          wk_valid_o,
    output logic [TAG_W-1:0]              wk_tag_o,
    output logic [DATA_W-1:0]             wk_data_o,
    // four-phase result port
    output logic                          res_req_o,
    input  logic                          res_ack_i,
    output logic [TAG_W-1:0]              res_tag_o,
    output logic [DATA_W-1:0]             res_data_o
);

    res_state_e       state_q;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] alu_res;
    logic              fire;
    logic              wk_q;

    assign a = iss_src_data_i[0];
    assign b = iss_src_data_i[1];

    always_comb begin
        case (iss_op_i)
            ADD:     alu_res = a + b;
            SUB:     alu_res = a - b;
            AND:     alu_res = a & b;
            OR:      alu_res = a | b;
            XOR:     alu_res = a ^ b;
            SLL:     alu_res = a << b[3:0];
            SRL:     alu_res = a >> b[3:0];
            SLT:     alu_res = ($signed(a) < $signed(b)) ? DATA_W'(1) : '0;
            default: alu_res = '0;
        endcase
    end

    assign iss_ready_o = (state_q == RES_IDLE);
    assign fire        = iss_valid_i && iss_ready_o;

    // ------------------------------
    // result handshake
    // ------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= RES_IDLE;
            wk_q    <= 1'b0;
        end else begin
            // wakeup is a single pulse right after issue
            wk_q <= fire;
            case (state_q)
                RES_IDLE:     if (fire) state_q <= RES_REQ;
                RES_REQ:      if (res_ack_i) state_q <= RES_WAIT_LOW;
                RES_WAIT_LOW: if (!res_ack_i) state_q <= RES_IDLE;
                default:      state_q <= RES_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            res_data_o <= alu_res;
            res_tag_o  <= iss_dst_tag_i;
        end
    end

    assign res_req_o  = (state_q == RES_REQ);
    assign wk_valid_o = wk_q;
    assign wk_tag_o   = res_tag_o;
    assign wk_data_o  = res_data_o;

    // ack rises only against a pending request
    a_ack_on_req: assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(res_ack_i) |-> res_req_o);

    // ack held until the request drops
    a_ack_held: assert property (@(posedge clk) disable iff (!arst_n_i)
        res_ack_i && res_req_o |=> res_ack_i);

endmodule

// File: issue_queue/issue_queue.sv
module issue_queue import alu_iq_pkg::*; (
    input  logic                          clk,
    input  logic                          arst_n_i,
    // allocation from dispatch
    input  logic                          alloc_valid_i,
    output logic                          alloc_ready_o,
    input  alu_op_e                       alloc_op_i,
    input  logic [TAG_W-1:0]              alloc_dst_tag_i,
    input  logic [1:0]                    alloc_src_rdy_i,
    input  logic [1:0][TAG_W-1:0]         alloc_src_tag_i,
    input  logic [1:0][DATA_W-1:0]        alloc_src_data_i,
    // wakeup buses
    input  logic                          cdb_valid_i,
    input  logic [TAG_W-1:0]              cdb_tag_i,
    input  logic [DATA_W-1:0]             cdb_data_i,
    input  logic                          wk_valid_i,
    input  logic [TAG_W-1:0]              wk_tag_i,
    input  logic [DATA_W-1:0]             wk_data_i,
    // issue to the ALU
    output logic                          iss_valid_o,
    input  logic                          iss_ready_i,
    output alu_op_e                       iss_op_o,
    output logic [TAG_W-1:0]              iss_dst_tag_o,
    output logic [1:0][DATA_W-1:0]        iss_src_data_o
);

    logic [IQ_SIZE-1:0]       free_q;
    logic [IQ_SIZE-1:0]       ent_occ;
    logic [IQ_SIZE-1:0]       ent_rdy;
    logic [IQ_SIZE-1:0]       ent_init;
    logic [IQ_SIZE-1:0]       ent_free;
    alu_op_e                  ent_op   [IQ_SIZE];
    logic [TAG_W-1:0]         ent_dst  [IQ_SIZE];
    logic [1:0][DATA_W-1:0]   ent_data [IQ_SIZE];
    logic [AGE_W-1:0]         age_q    [IQ_SIZE];

    logic [IQ_IDX_W-1:0]      alloc_idx;
    logic [IQ_IDX_W-1:0]      win_lo;
    logic [IQ_IDX_W-1:0]      win_hi;
    logic [IQ_IDX_W-1:0]      sel_idx;
    logic [AGE_W:0]           key      [IQ_SIZE];
    logic                     write;
    logic                     fire;
    logic                     older_rdy;

    // ------------------------------
    // free slots
    // ------------------------------
    // lowest free index wins
    always_comb begin
        alloc_idx = '0;
        for (int i = IQ_SIZE - 1; i >= 0; i--) begin
            if (free_q[i]) alloc_idx = IQ_IDX_W'(i);
        end
    end

    assign alloc_ready_o = |free_q;
    assign write         = alloc_valid_i && alloc_ready_o;
    assign fire          = iss_valid_o && iss_ready_i;

    always_comb begin
        ent_init = '0;
        ent_free = '0;
        ent_init[alloc_idx] = write;
        ent_free[sel_idx]   = fire;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            free_q <= '1;
        end else begin
            free_q <= (free_q & ~ent_init) | ent_free;
        end
    end

    // ------------------------------
    // age, saturating
    // ------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < IQ_SIZE; i++) age_q[i] <= '0;
        end else begin
            for (int i = 0; i < IQ_SIZE; i++) begin
                if (ent_init[i]) begin
                    age_q[i] <= '0;
                end else if (ent_occ[i] && age_q[i] != '1) begin
                    age_q[i] <= age_q[i] + 1'b1;
                end
            end
        end
    end

    // ------------------------------
    // oldest-ready select
    // ------------------------------
    // ready bit on top so any ready entry beats a non-ready one
    always_comb begin
        for (int i = 0; i < IQ_SIZE; i++) key[i] = {ent_rdy[i], age_q[i]};
        // ties keep the lower index
        win_lo  = (key[1] > key[0]) ? IQ_IDX_W'(1) : IQ_IDX_W'(0);
        win_hi  = (key[3] > key[2]) ? IQ_IDX_W'(3) : IQ_IDX_W'(2);
        sel_idx = (key[win_hi] > key[win_lo]) ? win_hi : win_lo;
    end

    assign iss_valid_o    = |ent_rdy;
    assign iss_op_o       = ent_op[sel_idx];
    assign iss_dst_tag_o  = ent_dst[sel_idx];
    assign iss_src_data_o = ent_data[sel_idx];

    for (genvar i = 0; i < IQ_SIZE; i++) begin : gen_entry
        iq_entry iq_entry_inst (
            .clk         (clk),
            .arst_n_i    (arst_n_i),
            .init_i      (ent_init[i]),
            .free_i      (ent_free[i]),
            .op_i        (alloc_op_i),
            .dst_tag_i   (alloc_dst_tag_i),
            .src_rdy_i   (alloc_src_rdy_i),
            .src_tag_i   (alloc_src_tag_i),
            .src_data_i  (alloc_src_data_i),
            .cdb_valid_i (cdb_valid_i),
            .cdb_tag_i   (cdb_tag_i),
            .cdb_data_i  (cdb_data_i),
            .wk_valid_i  (wk_valid_i),
            .wk_tag_i    (wk_tag_i),
            .wk_data_i   (wk_data_i),
            .occupied_o  (ent_occ[i]),
            .ready_o     (ent_rdy[i]),
            .op_o        (ent_op[i]),
            .dst_tag_o   (ent_dst[i]),
            .src_data_o  (ent_data[i])
        );
    end

    // any ready entry strictly older than the selected one
    always_comb begin
        older_rdy = 1'b0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (ent_rdy[i] && age_q[i] > age_q[sel_idx]) older_rdy = 1'b1;
        end
    end

    a_issue_oldest: assert property (@(posedge clk) disable iff (!arst_n_i)
        fire |-> ent_rdy[sel_idx] && !older_rdy);

    // free mask and entry occupancy must agree
    a_write_free_slot: assert property (@(posedge clk) disable iff (!arst_n_i)
        write |-> !ent_occ[alloc_idx]);

endmodule

// File: issue_queue/iq_entry.sv
module iq_entry import alu_iq_pkg::*; (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          init_i,
    input  logic                          free_i,
    input  alu_op_e                       op_i,
    input  logic [TAG_W-1:0]              dst_tag_i,
    input  logic [1:0]                    src_rdy_i,
    input  logic [1:0][TAG_W-1:0]         src_tag_i,
    input  logic [1:0][DATA_W-1:0]        src_data_i,
    input  logic                          cdb_valid_i,
    input  logic [TAG_W-1:0]              cdb_tag_i,
    input  logic [DATA_W-1:0]             cdb_data_i,
    input  logic                          wk_valid_i,
    input  logic [TAG_W-1:0]              wk_tag_i,
    input  logic [DATA_W-1:0]             wk_data_i,
    output logic                          occupied_o,
    output logic                          ready_o,
    output alu_op_e                       op_o,
    output logic [TAG_W-1:0]              dst_tag_o,
    output logic [1:0][DATA_W-1:0]        src_data_o
);

    logic                     occ_q;
    logic [1:0]               rdy_q;
    logic [1:0][TAG_W-1:0]    tag_q;
    logic [1:0]               cur_rdy;
    logic [1:0][TAG_W-1:0]    cur_tag;
    logic [1:0][DATA_W-1:0]   cur_data;
    logic [1:0]               nxt_rdy;
    logic [1:0][DATA_W-1:0]   nxt_data;
    logic [1:0]               cdb_hit;
    logic [1:0]               wk_hit;

    // snoop on the incoming tags at write time, else on the held ones
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            cur_rdy[s]  = init_i ? src_rdy_i[s]  : rdy_q[s];
            cur_tag[s]  = init_i ? src_tag_i[s]  : tag_q[s];
            cur_data[s] = init_i ? src_data_i[s] : src_data_o[s];
            cdb_hit[s]  = cdb_valid_i && !cur_rdy[s] && (cdb_tag_i == cur_tag[s]);
            wk_hit[s]   = wk_valid_i && !cur_rdy[s] && (wk_tag_i == cur_tag[s]);
            nxt_rdy[s]  = cur_rdy[s] || cdb_hit[s] || wk_hit[s];
            if (wk_hit[s]) begin
                nxt_data[s] = wk_data_i;
            end else if (cdb_hit[s]) begin
                nxt_data[s] = cdb_data_i;
            end else begin
                nxt_data[s] = cur_data[s];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            occ_q <= 1'b0;
            rdy_q <= '0;
        end else begin
            if (init_i) begin
                occ_q <= 1'b1;
            end else if (free_i) begin
                occ_q <= 1'b0;
            end
            if (init_i || occ_q) rdy_q <= nxt_rdy;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (init_i) begin
            op_o      <= op_i;
            dst_tag_o <= dst_tag_i;
            tag_q     <= src_tag_i;
        end
        if (init_i || occ_q) src_data_o <= nxt_data;
    end

    assign occupied_o = occ_q;
    assign ready_o    = occ_q && (&rdy_q);

endmodule

// File: rtl/dispatch_ctrl.sv
module dispatch_ctrl import alu_iq_pkg::*; (
    input  logic                          clk,
    input  logic                          arst_n_i,
    // four-phase dispatch port
    input  logic                          dsp_req_i,
    input  alu_op_e                       dsp_op_i,
    input  logic [TAG_W-1:0]              dsp_dst_tag_i,
    input  logic [1:0]                    dsp_src_rdy_i,
    input  logic [1:0][TAG_W-1:0]         dsp_src_tag_i,
    input  logic [1:0][DATA_W-1:0]        dsp_src_data_i,
    output logic                          dsp_ack_o,
    // allocation into the issue queue
    output logic                          alloc_valid_o,
    input  logic                          alloc_ready_i,
    output alu_op_e                       alloc_op_o,
    output logic [TAG_W-1:0]              alloc_dst_tag_o,
    output logic [1:0]                    alloc_src_rdy_o,
    output logic [1:0][TAG_W-1:0]         alloc_src_tag_o,
    output logic [1:0][DATA_W-1:0]        alloc_src_data_o
);

    disp_state_e state_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= DISP_IDLE;
        end else begin
            case (state_q)
                DISP_IDLE:  if (dsp_req_i) state_q <= DISP_WRITE;
                DISP_WRITE: if (alloc_ready_i) state_q <= DISP_ACKED;
                // hold ack until the sender lets go of req
                DISP_ACKED: if (!dsp_req_i) state_q <= DISP_IDLE;
                default:    state_q <= DISP_IDLE;
            endcase
        end
    end

    // payload latched once, when req is first seen
    always_ff @(posedge clk) begin
        if (state_q == DISP_IDLE && dsp_req_i) begin
            alloc_op_o       <= dsp_op_i;
            alloc_dst_tag_o  <= dsp_dst_tag_i;
            alloc_src_rdy_o  <= dsp_src_rdy_i;
            alloc_src_tag_o  <= dsp_src_tag_i;
            alloc_src_data_o <= dsp_src_data_i;
        end
    end

    assign alloc_valid_o = (state_q == DISP_WRITE);
    assign dsp_ack_o     = (state_q == DISP_ACKED);

    // sender keeps req up until it has seen ack
    a_req_until_ack: assert property (@(posedge clk) disable iff (!arst_n_i)
        $fell(dsp_req_i) |-> $past(dsp_ack_o));

    // a new req only once the previous ack is gone
    a_req_after_ack_low: assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(dsp_req_i) |-> !dsp_ack_o);

endmodule

// File: common/alu_iq_pkg.sv
package alu_iq_pkg;

    // ------------------------------
    // widths and sizes
    // ------------------------------
    localparam int DATA_W   = 16;
    localparam int TAG_W    = 4;
    localparam int IQ_SIZE  = 4;
    localparam int IQ_IDX_W = 2;
    // saturating age counter per queue entry
    localparam int AGE_W    = 4;

    // ------------------------------
    // opcodes
    // ------------------------------
    // shifts use the low 4 bits of operand 1, SLT is signed
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        SLT = 3'd7
    } alu_op_e;

    // ------------------------------
    // state machines
    // ------------------------------
    // dispatch receiver, four-phase
    typedef enum logic [1:0] {
        DISP_IDLE,
        DISP_WRITE,
        DISP_ACKED
    } disp_state_e;

    // result sender, four-phase
    typedef enum logic [1:0] {
        RES_IDLE,
        RES_REQ,
        RES_WAIT_LOW
    } res_state_e;

endpackage
